// ==== Bender.yml ====
package:
  name: uart_softmax

sources:
  - files:
      - hw/smx_pkg.sv
      - hw/uart_rx.sv
      - hw/uart_tx.sv
      - hw/block_buffer.sv
      - hw/softmax_approx.sv
      - hw/uart_softmax_top.sv
  - target: test
    files:
      - tests/uart_softmax_chk.sv
      - tests/tb_uart_softmax.sv

// ==== build.f ====
hw/smx_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/block_buffer.sv
hw/softmax_approx.sv
hw/uart_softmax_top.sv
tests/uart_softmax_chk.sv
tests/tb_uart_softmax.sv

// ==== hw/block_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module block_buffer
    import smx_pkg::*;
#(
    parameter int N = 64
) (
    input  logic                      clk,
    input  logic                      rst,
    input  byte_t                     rx_data,
    input  logic                      rx_valid,
    input  logic                      consume,
    input  logic [$clog2(2*N)-1:0]    rd_addr,
    output byte_t                     rd_data,
    output logic                      block_ready,
    output logic                      overrun
);

    localparam int AW = $clog2(2 * N);

    byte_t         mem [2*N];
    logic [AW-1:0] wr_ptr;
    logic          wr_en;

    assign wr_en = rx_valid && !block_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr      <= '0;
            block_ready <= 1'b0;
            overrun     <= 1'b0;
        end else begin
            if (rx_valid && block_ready) begin
                overrun <= 1'b1;  // Sticky until reset.
            end
            if (consume) begin
                block_ready <= 1'b0;
                wr_ptr      <= '0;
            end else if (wr_en) begin
                if (wr_ptr == AW'(2 * N - 1)) begin
                    block_ready <= 1'b1;
                    wr_ptr      <= '0;
                end else begin
                    wr_ptr <= wr_ptr + AW'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= rx_data;
        end
        rd_data <= mem[rd_addr];  // One cycle read latency.
    end

endmodule

`default_nettype wire

// ==== hw/smx_pkg.sv ====
`default_nettype none

package smx_pkg;

    typedef logic [15:0] data_t;  // Q8.8 signed in, Q1.15 unsigned out.
    typedef logic [15:0] exp_t;
    typedef logic [23:0] sum_t;
    typedef logic [7:0]  byte_t;

    // Top-level sequencer.
    typedef enum logic [2:0] {
        wait_blk,
        rd_lo,
        rd_hi,
        sm_req,
        sm_wait,
        tx_bytes,
        consume,
        wait_clr
    } seq_state_t;

    // Softmax engine passes.
    typedef enum logic [2:0] {
        idle,
        max_pass,
        exp_pass,
        div_pass,
        done
    } eng_state_t;

endpackage

`default_nettype wire

// ==== hw/softmax_approx.sv ====
`timescale 1ns/100ps
`default_nettype none

module softmax_approx
    import smx_pkg::*;
#(
    parameter int N = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            req,
    input  logic [N*16-1:0] in_x_flat,
    output logic            ack,
    output logic [N*16-1:0] prob_flat
);

    localparam int IW = $clog2(N);

    eng_state_t    state;
    logic [IW-1:0] idx;
    logic [4:0]    div_cnt;  // 0 loads, 1..16 produce quotient bits.

    data_t x_mem [N];
    exp_t  e_mem [N];
    data_t max_x;
    sum_t  sum;

    sum_t        rem;
    logic [15:0] dvd_lo;
    logic [15:0] quo;

    exp_t        e_cur;
    logic [24:0] trial;
    logic        ge;
    sum_t        rem_next;
    logic        last_idx;

    // exp(-d) in base 2 with a linear mantissa.
    function automatic exp_t exp_approx(input data_t m, input data_t x);
        logic [16:0] d;
        logic [7:0]  k;
        logic [15:0] mant;
        d    = {m[15], m} - {x[15], x};
        k    = d[15:8];
        mant = 16'hFFFF - {1'b0, d[7:0], 7'b0};
        if (k >= 8'd16) begin
            return '0;
        end
        return mant >> k[3:0];
    endfunction

    assign e_cur    = exp_approx(max_x, x_mem[idx]);
    assign last_idx = (idx == IW'(N - 1));

    // ========================================
    // Restoring divider step
    // ========================================
    assign trial    = {rem, dvd_lo[15]};
    assign ge       = (trial >= {1'b0, sum});
    assign rem_next = ge ? 24'(trial - {1'b0, sum}) : trial[23:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= idle;
            idx     <= '0;
            div_cnt <= '0;
            ack     <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (req) begin
                        idx   <= '0;
                        state <= max_pass;
                    end
                end
                max_pass: begin
                    idx <= last_idx ? '0 : idx + IW'(1);
                    if (last_idx) state <= exp_pass;
                end
                exp_pass: begin
                    idx <= last_idx ? '0 : idx + IW'(1);
                    if (last_idx) begin
                        div_cnt <= '0;
                        state   <= div_pass;
                    end
                end
                div_pass: begin
                    if (div_cnt == 5'd16) begin
                        div_cnt <= '0;
                        idx     <= idx + IW'(1);
                        if (last_idx) state <= done;
                    end else begin
                        div_cnt <= div_cnt + 5'd1;
                    end
                end
                done: begin
                    if (!ack) begin
                        ack <= 1'b1;
                    end else if (!req) begin
                        ack   <= 1'b0;  // Four-phase return to zero.
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            idle: begin
                if (req) begin
                    for (int i = 0; i < N; i++) begin
                        x_mem[i] <= in_x_flat[16*i +: 16];
                    end
                    max_x <= in_x_flat[15:0];
                    sum   <= '0;
                end
            end
            max_pass: begin
                if ($signed(x_mem[idx]) > $signed(max_x)) max_x <= x_mem[idx];
            end
            exp_pass: begin
                e_mem[idx] <= e_cur;
                sum        <= sum + sum_t'(e_cur);
            end
            div_pass: begin
                if (div_cnt == 5'd0) begin
                    // Top 15 dividend bits are e >> 1, always below S.
                    rem    <= sum_t'(e_mem[idx] >> 1);
                    dvd_lo <= {e_mem[idx][0], 15'b0};
                    quo    <= '0;
                end else begin
                    rem    <= rem_next;
                    dvd_lo <= {dvd_lo[14:0], 1'b0};
                    quo    <= {quo[14:0], ge};
                    if (div_cnt == 5'd16) prob_flat[16*idx +: 16] <= {quo[14:0], ge};
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/uart_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_rx
    import smx_pkg::*;
#(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  rxd,
    output byte_t rx_data,
    output logic  rx_valid
);

    localparam int CW = $clog2(CLKS_PER_BIT);

    logic          rx_meta;
    logic          rx_s;
    logic          busy;
    logic [CW-1:0] clk_cnt;
    logic [3:0]    bit_idx;  // 0 start, 1..8 data, 9 stop.
    byte_t         shreg;

    logic sample;

    assign sample  = busy && (clk_cnt == '0);
    assign rx_data = shreg;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_meta  <= 1'b1;
            rx_s     <= 1'b1;
            busy     <= 1'b0;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_meta  <= rxd;
            rx_s     <= rx_meta;
            rx_valid <= 1'b0;
            if (!busy) begin
                if (!rx_s) begin  // Falling edge of start bit.
                    busy    <= 1'b1;
                    clk_cnt <= CW'(CLKS_PER_BIT / 2 - 1);
                    bit_idx <= '0;
                end
            end else if (sample) begin
                clk_cnt <= CW'(CLKS_PER_BIT - 1);
                bit_idx <= bit_idx + 4'd1;
                if (bit_idx == 4'd0 && rx_s) begin
                    busy <= 1'b0;  // Glitch, not a start bit.
                end
                if (bit_idx == 4'd9) begin
                    busy     <= 1'b0;
                    rx_valid <= rx_s;  // Bad stop bit drops the byte.
                end
            end else begin
                clk_cnt <= clk_cnt - CW'(1);
            end
        end
    end

    // Data bits arrive LSB first.
    always_ff @(posedge clk) begin
        if (sample && bit_idx != 4'd0 && bit_idx != 4'd9) begin
            shreg <= {rx_s, shreg[7:1]};
        end
    end

endmodule

`default_nettype wire

// ==== hw/uart_softmax_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_softmax_top
    import smx_pkg::*;
#(
    parameter int N            = 64,
    parameter int CLKS_PER_BIT = 868
) (
    input  logic clk,
    input  logic rst,
    input  logic rxd,
    output logic txd,
    output logic overrun
);

    localparam int AW = $clog2(2 * N);
    localparam int IW = $clog2(N);

    byte_t           rx_data;
    logic            rx_valid;
    logic            block_ready;
    logic            buf_consume;
    logic [AW-1:0]   rd_addr;
    byte_t           rd_data;
    logic            req;
    logic            ack;
    logic [N*16-1:0] in_x_flat;
    logic [N*16-1:0] prob_flat;
    logic            tx_start;
    byte_t           tx_byte;
    logic            tx_active;
    logic            tx_done;

    seq_state_t    state;
    logic [IW-1:0] widx;
    logic [AW-1:0] tx_idx;
    logic          tx_wait;
    byte_t         lo_byte;
    data_t         y_word [N];

    logic last_word;
    logic tx_fire;

    // ========================================
    // Datapath blocks
    // ========================================
    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_rx (
        .clk      (clk),
        .rst      (rst),
        .rxd      (rxd),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    block_buffer #(.N(N)) i_block_buffer (
        .clk         (clk),
        .rst         (rst),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .consume     (buf_consume),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .block_ready (block_ready),
        .overrun     (overrun)
    );

    softmax_approx #(.N(N)) i_softmax_approx (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .in_x_flat (in_x_flat),
        .ack       (ack),
        .prob_flat (prob_flat)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_tx (
        .clk       (clk),
        .rst       (rst),
        .start     (tx_start),
        .tx_byte   (tx_byte),
        .tx_active (tx_active),
        .txd       (txd),
        .tx_done   (tx_done)
    );

    assign last_word = (widx == IW'(N - 1));
    assign tx_fire   = (state == tx_bytes) && !tx_wait && !tx_active;

    // ========================================
    // Sequencer
    // ========================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= wait_blk;
            widx        <= '0;
            rd_addr     <= '0;
            tx_idx      <= '0;
            tx_wait     <= 1'b0;
            req         <= 1'b0;
            tx_start    <= 1'b0;
            buf_consume <= 1'b0;
        end else begin
            tx_start    <= 1'b0;
            buf_consume <= 1'b0;
            case (state)
                wait_blk: begin
                    // rd_addr rests at 0, so byte 0 is already on rd_data.
                    if (block_ready && !ack) begin
                        widx    <= '0;
                        rd_addr <= AW'(1);
                        state   <= rd_lo;
                    end
                end
                rd_lo: begin
                    rd_addr <= rd_addr + AW'(1);
                    state   <= rd_hi;
                end
                rd_hi: begin
                    if (last_word) begin
                        rd_addr <= '0;
                        state   <= sm_req;
                    end else begin
                        rd_addr <= rd_addr + AW'(1);
                        widx    <= widx + IW'(1);
                        state   <= rd_lo;
                    end
                end
                sm_req: begin
                    req   <= 1'b1;
                    state <= sm_wait;
                end
                sm_wait: begin
                    if (ack) begin
                        req     <= 1'b0;  // Results latched this cycle.
                        tx_idx  <= '0;
                        tx_wait <= 1'b0;
                        state   <= tx_bytes;
                    end
                end
                tx_bytes: begin
                    if (tx_fire) begin
                        tx_start <= 1'b1;
                        tx_wait  <= 1'b1;
                    end else if (tx_wait && tx_done) begin
                        tx_wait <= 1'b0;
                        if (tx_idx == AW'(2 * N - 1)) state <= consume;
                        else tx_idx <= tx_idx + AW'(1);
                    end
                end
                consume: begin
                    buf_consume <= 1'b1;
                    state       <= wait_clr;
                end
                wait_clr: begin
                    if (!block_ready) state <= wait_blk;
                end
                default: state <= wait_blk;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == rd_lo) lo_byte <= rd_data;
        if (state == rd_hi) in_x_flat[16*widx +: 16] <= {rd_data, lo_byte};
        if (state == sm_wait && ack) begin
            for (int i = 0; i < N; i++) begin
                y_word[i] <= prob_flat[16*i +: 16];
            end
        end
        if (tx_fire) begin
            tx_byte <= tx_idx[0] ? y_word[tx_idx[AW-1:1]][15:8]
                                 : y_word[tx_idx[AW-1:1]][7:0];  // Low byte first.
        end
    end

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_tx
    import smx_pkg::*;
#(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  byte_t tx_byte,
    output logic  tx_active,
    output logic  txd,
    output logic  tx_done
);

    localparam int CW = $clog2(CLKS_PER_BIT);

    logic [CW-1:0] clk_cnt;
    logic [3:0]    bit_idx;
    logic [9:0]    frame;  // Current bit sits in frame[0].

    logic launch;
    logic bit_end;

    assign launch  = start && !tx_active;
    assign bit_end = tx_active && (clk_cnt == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_active <= 1'b0;
            txd       <= 1'b1;
            tx_done   <= 1'b0;
            clk_cnt   <= '0;
            bit_idx   <= '0;
        end else begin
            tx_done <= 1'b0;
            if (launch) begin
                tx_active <= 1'b1;
                txd       <= 1'b0;  // Start bit.
                clk_cnt   <= CW'(CLKS_PER_BIT - 1);
                bit_idx   <= '0;
            end else if (bit_end) begin
                if (bit_idx == 4'd9) begin
                    tx_active <= 1'b0;
                    tx_done   <= 1'b1;
                    txd       <= 1'b1;
                end else begin
                    txd     <= frame[1];
                    bit_idx <= bit_idx + 4'd1;
                    clk_cnt <= CW'(CLKS_PER_BIT - 1);
                end
            end else if (tx_active) begin
                clk_cnt <= clk_cnt - CW'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            frame <= {1'b1, tx_byte, 1'b0};
        end else if (bit_end) begin
            frame <= {1'b1, frame[9:1]};
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_uart_softmax.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_uart_softmax
    import smx_pkg::*;
#(
    parameter int N            = 8,
    parameter int CLKS_PER_BIT = 16
) ();

    localparam int NUM_BLOCKS = 9;
    localparam int LIMIT      = NUM_BLOCKS * (4 * N * 10 * CLKS_PER_BIT + 40 * N) + 4000;

    logic clk = 1'b0;
    logic rst;
    logic rxd;
    logic txd;
    logic overrun;

    logic [15:0] lfsr_state = 16'd11219;
    data_t       blk [N];       // Words of the block in flight.
    data_t       expect_w [N];
    byte_t       reply_q [$];
    int          errors = 0;
    int          checks = 0;
    int          chk_fails;
    int          v;

    uart_softmax_top #(.N(N), .CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_softmax_top (
        .clk     (clk),
        .rst     (rst),
        .rxd     (rxd),
        .txd     (txd),
        .overrun (overrun)
    );

    always #50 clk = ~clk;

    // ========================================
    // Random numbers and reference model
    // ========================================
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];  // x^16 + x^14 + x^13 + x^11 + 1.
        return {s[14:0], fb};
    endfunction

    task automatic rand_bits(input int n, output int r);
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = (r << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic softmax_model();
        int     m;
        int     d;
        int     e [N];
        longint s;
        m = $signed(blk[0]);
        for (int i = 1; i < N; i++) begin
            if ($signed(blk[i]) > m) m = $signed(blk[i]);
        end
        s = 0;
        for (int i = 0; i < N; i++) begin
            d = m - $signed(blk[i]);
            // Integer part shifts, fraction scales the mantissa down.
            e[i] = ((d / 256) >= 16) ? 0 : (65535 - (d % 256) * 128) >> (d / 256);
            s = s + e[i];
        end
        s = s % (64'd1 << 24);
        for (int i = 0; i < N; i++) begin
            expect_w[i] = data_t'((longint'(e[i]) * 32768) / s);
        end
    endtask

    // ========================================
    // Serial driver and reply monitor
    // ========================================
    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #10 rxd = frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic send_block();
        for (int i = 0; i < N; i++) begin
            send_byte(blk[i][7:0]);  // Low byte first.
            send_byte(blk[i][15:8]);
        end
    endtask

    initial begin : reply_monitor
        byte_t b;
        forever begin
            @(negedge clk);
            if (rst === 1'b0 && txd === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(negedge clk);
                assert (txd === 1'b0) else begin
                    errors++;
                    $display("Start bit on txd did not last to mid-bit");
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    b[i] = txd;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                assert (txd === 1'b1) else begin
                    errors++;
                    $display("Stop bit on txd was low");
                end
                reply_q.push_back(b);
            end
        end
    end

    task automatic check_value(input string name, input int idx, input int exp_v, input int got);
        checks++;
        assert (got === exp_v) else begin
            errors++;
            $display("Error: %s word %0d expected %0d actual %0d", name, idx, exp_v, got);
        end
    endtask

    task automatic check_reply(input string name);
        byte_t lo;
        byte_t hi;
        softmax_model();
        while (reply_q.size() < 2 * N) @(posedge clk);
        for (int i = 0; i < N; i++) begin
            lo = reply_q.pop_front();
            hi = reply_q.pop_front();
            check_value(name, i, int'(expect_w[i]), int'({hi, lo}));
        end
    endtask

    task automatic run_block(input string name);
        send_block();
        check_reply(name);
        repeat (2 * CLKS_PER_BIT) @(posedge clk);  // Idle gap before the next block.
    endtask

    task automatic fill_random();
        for (int i = 0; i < N; i++) begin
            rand_bits(11, v);
            blk[i] = data_t'(v - 1024);  // Within +-4.0 in Q8.8.
        end
    endtask

    // ========================================
    // Watchdog
    // ========================================
    initial begin : watchdog
        repeat (LIMIT) @(posedge clk);
        $display("Timeout: the DUT reply did not complete within %0d cycles", LIMIT);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        rxd = 1'b1;
        repeat (4) @(posedge clk);
        #10 rst = 1'b0;

        fill_random();
        run_block("random_block");

        rand_bits(11, v);
        for (int i = 0; i < N; i++) blk[i] = data_t'(v - 1024);
        run_block("all_equal");

        rand_bits(3, v);
        for (int i = 0; i < N; i++) begin
            rand_bits(8, blk[i]);
            blk[i] = data_t'(-4096 + int'(blk[i]));  // Near -16.0.
        end
        blk[v] = 16'sd1280;  // 5.0, over 20.0 above the rest.
        run_block("dominant");

        for (int b = 0; b < 5; b++) begin
            fill_random();
            run_block($sformatf("back_to_back_%0d", b));
        end

        check_value("overrun_before", 0, 0, int'(overrun));
        fill_random();
        send_block();
        for (int i = 0; i < 3; i++) begin
            rand_bits(8, v);
            send_byte(byte_t'(v));
        end
        check_value("overrun_set", 0, 1, int'(overrun));
        check_reply("overrun_reply");
        repeat (30 * CLKS_PER_BIT) @(posedge clk);
        check_value("overrun_sticky", 0, 1, int'(overrun));
        assert (reply_q.size() == 0) else begin
            errors++;
            $display("DUT sent %0d reply bytes after the last block", reply_q.size());
        end

        chk_fails = i_uart_softmax_top.i_uart_softmax_chk.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, chk_fails);
        if (errors == 0 && chk_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/uart_softmax_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_softmax_chk #(
    parameter int W = 128
) (
    input logic         clk,
    input logic         rst,
    input logic         req,
    input logic         ack,
    input logic [W-1:0] prob_flat,
    input logic         start,
    input logic         tx_active
);

    int fail_count = 0;

    // ========================================
    // Engine handshake
    // ========================================
    ack_needs_req: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req)
        else begin
            fail_count++;
            $error("ack rose while req was low");
        end

    req_held: assert property (@(posedge clk) disable iff (rst) (req && !ack) |=> req)
        else begin
            fail_count++;
            $error("req dropped before ack rose");
        end

    prob_stable: assert property (@(posedge clk) disable iff (rst) ack |-> $stable(prob_flat))
        else begin
            fail_count++;
            $error("prob_flat changed while ack was high");
        end

    // Transmitter accepts a start only when idle.
    start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !tx_active)
        else begin
            fail_count++;
            $error("start arrived while the transmitter was active");
        end

endmodule

// Watches the ports of the engine and the transmitter from inside the top level.
bind uart_softmax_top uart_softmax_chk #(.W(N * 16)) i_uart_softmax_chk (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .ack       (ack),
    .prob_flat (prob_flat),
    .start     (tx_start),
    .tx_active (tx_active)
);

`default_nettype wire
